// ==== Makefile ====
VERILATOR    ?= verilator
TOP          := fpu_cvt_tb
RTL_TOP      := fpu_cvt_unit
FILELIST     := fpu_cvt.f
COMMON_FLAGS := --timing --assert --timescale 1ns/1ns -Wno-fatal
LINT_FLAGS   := --lint-only $(COMMON_FLAGS)
SIM_FLAGS    := --binary $(COMMON_FLAGS)
OBJ_DIR      := obj_dir
BIN          := $(OBJ_DIR)/V$(TOP)
LOG          := sim.log
PASS_MSG     := TESTS PASSED
SOURCES      := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv tests/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== fpu_cvt.f ====
+incdir+hdl
+incdir+tests
hdl/fpu_types_pkg.sv
hdl/float_cvt_int_to_half.sv
hdl/float_cvt_half_to_int.sv
hdl/fpu_cvt_unit.sv
tests/fpu_cvt_tb.sv

// ==== hdl/float_cvt_half_to_int.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpu_cvt_config.svh"

// IEEE binary16 to signed int32, purely combinational
module float_cvt_half_to_int
    import fpu_types_pkg::*;
(
    input  logic [`FPU_HALF_WIDTH-1:0]    float16,
    input  round_mode_e                   rm,
    output logic [`FPU_CVT_INT_WIDTH-1:0] int32,
    output fpu_flags_t                    flags
);

    // Decoded fields
    logic                                          sign;
    logic [`FPU_HALF_EXP_WIDTH-1:0]                exp_field;
    logic [`FPU_HALF_MAN_WIDTH-1:0]                man_field;
    logic                                          is_special;
    logic                                          is_nan;

    // Effective exponent and significand with hidden bit
    logic [`FPU_HALF_EXP_WIDTH-1:0]                exp_eff;
    logic [`FPU_HALF_MAN_WIDTH:0]                  significand;

    // Alignment in either direction
    logic                                          shift_left;
    logic [`FPU_HALF_EXP_WIDTH-1:0]                left_amt;
    logic [`FPU_HALF_EXP_WIDTH-1:0]                right_amt;
    logic [`FPU_CVT_INT_WIDTH-1:0]                 left_value;
    logic [`FPU_HALF_MAN_WIDTH+`FPU_HALF_FRAC_SPAN:0] right_window;

    // Integer part before rounding, guard and sticky
    logic [`FPU_CVT_INT_WIDTH-1:0]                 int_mag;
    logic                                          guard;
    logic                                          sticky;
    logic                                          round_up;
    logic [`FPU_CVT_INT_WIDTH-1:0]                 mag_rounded;

    assign sign      = float16[`FPU_HALF_WIDTH-1];
    assign exp_field = float16[`FPU_HALF_WIDTH-2 -: `FPU_HALF_EXP_WIDTH];
    assign man_field = float16[`FPU_HALF_MAN_WIDTH-1:0];

    assign is_special = (exp_field == `FPU_HALF_EXP_SPECIAL);
    assign is_nan     = is_special && (man_field != '0);

    // Subnormals share the exponent of the smallest normal
    assign exp_eff     = (exp_field == '0) ?
                         {{(`FPU_HALF_EXP_WIDTH-1){1'b0}}, 1'b1} : exp_field;
    assign significand = {(exp_field != '0), man_field};

    // At or above the point exponent the value is a whole number
    assign shift_left = (exp_eff >= `FPU_HALF_POINT_EXP);
    assign left_amt   = exp_eff - `FPU_HALF_POINT_EXP;
    assign right_amt  = `FPU_HALF_POINT_EXP - exp_eff;

    // Largest finite half needs only five bits of left shift
    assign left_value = {{(`FPU_CVT_INT_WIDTH-`FPU_HALF_MAN_WIDTH-1){1'b0}}, significand}
                        << left_amt;

    // Fraction bits below the significand catch what shifts out
    assign right_window = {significand, {`FPU_HALF_FRAC_SPAN{1'b0}}} >> right_amt;

    always_comb begin
        if (shift_left) begin
            int_mag = left_value;
            guard   = 1'b0;
            sticky  = 1'b0;
        end else begin
            int_mag = {{(`FPU_CVT_INT_WIDTH-`FPU_HALF_MAN_WIDTH-1){1'b0}},
                       right_window[`FPU_HALF_MAN_WIDTH+`FPU_HALF_FRAC_SPAN -:
                                    `FPU_HALF_MAN_WIDTH+1]};
            // First bit below the binary point
            guard   = right_window[`FPU_HALF_FRAC_SPAN-1];
            sticky  = |right_window[`FPU_HALF_FRAC_SPAN-2:0];
        end
    end

    assign round_up    = round_increment(rm, sign, int_mag[0], guard, sticky);
    // 65504 plus one never reaches the sign bit
    assign mag_rounded = int_mag + {{(`FPU_CVT_INT_WIDTH-1){1'b0}}, round_up};

    // Specials saturate, everything else takes the rounded value
    always_comb begin
        flags = '0;
        if (is_nan || (is_special && !sign)) begin
            int32    = {1'b0, {(`FPU_CVT_INT_WIDTH-1){1'b1}}};
            flags.nv = 1'b1;
        end else if (is_special) begin
            // Negative infinity
            int32    = {1'b1, {(`FPU_CVT_INT_WIDTH-1){1'b0}}};
            flags.nv = 1'b1;
        end else begin
            int32    = sign ? (~mag_rounded + 1'b1) : mag_rounded;
            flags.nx = guard | sticky;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/float_cvt_int_to_half.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpu_cvt_config.svh"

// Signed int32 to IEEE binary16, purely combinational
module float_cvt_int_to_half
    import fpu_types_pkg::*;
(
    input  logic [`FPU_CVT_INT_WIDTH-1:0] int32,
    input  round_mode_e                   rm,
    output logic [`FPU_HALF_WIDTH-1:0]    float16,
    output fpu_flags_t                    flags
);

    // Sign and unsigned magnitude
    logic                           sign;
    logic [`FPU_CVT_INT_WIDTH-1:0]  magnitude;

    // Leading one position and normalizing shift
    logic [4:0]                     msb_pos;
    logic [4:0]                     shift_amt;
    logic [`FPU_CVT_INT_WIDTH-1:0]  normalized;

    // Hidden bit plus mantissa, and the dropped bits
    logic [`FPU_HALF_MAN_WIDTH:0]   kept;
    logic                           guard;
    logic                           sticky;

    // Rounded significand with one carry bit on top
    logic                           round_up;
    logic [`FPU_HALF_MAN_WIDTH+1:0] rounded;
    logic                           carry;

    // Biased exponent, wide enough to see overflow
    logic [5:0]                     biased_exp;
    logic                           overflow;
    logic                           sat_to_max;

    assign sign = int32[`FPU_CVT_INT_WIDTH-1];
    // Most negative input keeps its bit pattern as unsigned 2^31
    assign magnitude = sign ? (~int32 + 1'b1) : int32;

    // Highest set bit wins since the loop runs upward
    always_comb begin
        msb_pos = '0;
        for (int i = 0; i < `FPU_CVT_INT_WIDTH; i++) begin
            if (magnitude[i]) begin
                msb_pos = 5'(i);
            end
        end
    end

    // Move the leading one to the top bit
    assign shift_amt  = 5'(`FPU_CVT_INT_WIDTH - 1) - msb_pos;
    assign normalized = magnitude << shift_amt;

    // Eleven significant bits, then guard, then everything below as sticky
    assign kept   = normalized[`FPU_CVT_INT_WIDTH-1 -: `FPU_HALF_MAN_WIDTH+1];
    assign guard  = normalized[`FPU_CVT_INT_WIDTH-`FPU_HALF_MAN_WIDTH-2];
    assign sticky = |normalized[`FPU_CVT_INT_WIDTH-`FPU_HALF_MAN_WIDTH-3:0];

    assign round_up = round_increment(rm, sign, kept[0], guard, sticky);
    assign rounded  = {1'b0, kept} + {{(`FPU_HALF_MAN_WIDTH+1){1'b0}}, round_up};
    // All ones rounded up wraps the mantissa to zero
    assign carry    = rounded[`FPU_HALF_MAN_WIDTH+1];

    // Exponent of the leading one plus bias, bumped on carry
    assign biased_exp = {1'b0, msb_pos} + {5'b0, carry} + 6'(`FPU_HALF_EXP_BIAS);

    // Large magnitudes overflow in every mode
    // A rounding carry past the top finite exponent also overflows
    assign overflow = (magnitude >= `FPU_HALF_OVF_MAG) ||
                      (biased_exp > {1'b0, `FPU_HALF_EXP_MAX});

    // Pick max finite or infinity by direction of rounding
    always_comb begin
        case (rm)
            RM_RTZ:  sat_to_max = 1'b1;
            // Rounding down keeps positives finite
            RM_RDN:  sat_to_max = !sign;
            // Rounding up keeps negatives finite
            RM_RUP:  sat_to_max = sign;
            // Nearest modes go to infinity
            default: sat_to_max = 1'b0;
        endcase
    end

    // Result assembly and flags
    always_comb begin
        flags = '0;
        if (magnitude == '0) begin
            // Zero is always +0 and exact
            float16 = '0;
        end else if (overflow) begin
            if (sat_to_max) begin
                float16 = sign ? HALF_MAXN : HALF_MAX;
            end else begin
                float16 = sign ? HALF_INFN : HALF_INF;
            end
            flags.of = 1'b1;
            flags.nx = 1'b1;
        end else begin
            // Mantissa bits are already zero after a carry
            float16  = {sign,
                        biased_exp[`FPU_HALF_EXP_WIDTH-1:0],
                        rounded[`FPU_HALF_MAN_WIDTH-1:0]};
            // Any dropped nonzero bit
            flags.nx = guard | sticky;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fpu_cvt_config.svh ====
`ifndef FPU_CVT_CONFIG_SVH
`define FPU_CVT_CONFIG_SVH

// Integer operand width
`define FPU_CVT_INT_WIDTH 32

// Binary16 field layout
`define FPU_HALF_WIDTH 16
`define FPU_HALF_EXP_WIDTH 5
`define FPU_HALF_MAN_WIDTH 10
`define FPU_HALF_EXP_BIAS 15

// Largest biased exponent of a finite half value
`define FPU_HALF_EXP_MAX 5'd30
// Exponent field of infinity and NaN
`define FPU_HALF_EXP_SPECIAL 5'd31
// Biased exponent where the significand LSB has weight one
`define FPU_HALF_POINT_EXP 5'd25
// Fraction bits kept below the binary point in half to int alignment
`define FPU_HALF_FRAC_SPAN 24
// Smallest magnitude that overflows binary16 under any mode
`define FPU_HALF_OVF_MAG 32'd65520

`endif

// ==== hdl/fpu_cvt_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpu_cvt_config.svh"

// Conversion unit top, one register stage around two converters
module fpu_cvt_unit
    import fpu_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  cvt_req_t req,
    output logic     out_valid,
    output cvt_rsp_t rsp
);

    // Request stage
    cvt_req_t                      req_q;
    logic                          req_valid_q;

    // Converter outputs
    logic [`FPU_HALF_WIDTH-1:0]    i2h_result;
    fpu_flags_t                    i2h_flags;
    logic [`FPU_CVT_INT_WIDTH-1:0] h2i_result;
    fpu_flags_t                    h2i_flags;

    // Selected by opcode
    logic [`FPU_CVT_INT_WIDTH-1:0] sel_result;
    fpu_flags_t                    sel_flags;

    // Response stage
    logic [`FPU_CVT_INT_WIDTH-1:0] rsp_result_q;
    fpu_flags_t                    rsp_flags_q;

    // Strobe pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= in_valid;
        end
    end

    // Operand capture on strobe only
    always_ff @(posedge clk) begin
        if (in_valid) begin
            req_q <= req;
        end
    end

    float_cvt_int_to_half float_cvt_int_to_half_i (
        .int32   (req_q.operand),
        .rm      (req_q.rm),
        .float16 (i2h_result),
        .flags   (i2h_flags)
    );

    // Half operand is the low half of the request word
    float_cvt_half_to_int float_cvt_half_to_int_i (
        .float16 (req_q.operand[`FPU_HALF_WIDTH-1:0]),
        .rm      (req_q.rm),
        .int32   (h2i_result),
        .flags   (h2i_flags)
    );

    // Direction select, half results are zero-extended
    always_comb begin
        case (req_q.op)
            CVT_I2H: begin
                sel_result = {{(`FPU_CVT_INT_WIDTH-`FPU_HALF_WIDTH){1'b0}}, i2h_result};
                sel_flags  = i2h_flags;
            end
            default: begin
                sel_result = h2i_result;
                sel_flags  = h2i_flags;
            end
        endcase
    end

    // Output strobe and flags
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            rsp_flags_q <= '0;
        end else begin
            out_valid <= req_valid_q;
            // Flags hold until the next result
            if (req_valid_q) begin
                rsp_flags_q <= sel_flags;
            end
        end
    end

    // Result value holds until the next result
    always_ff @(posedge clk) begin
        if (req_valid_q) begin
            rsp_result_q <= sel_result;
        end
    end

    assign rsp = '{result: rsp_result_q, flags: rsp_flags_q};

    // Every strobe comes out two edges later
    a_valid_latency: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |=> ##1 out_valid
    );

    // No result without a matching strobe
    a_valid_origin: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, 2)
    );

    // Integer results saturate with nv, never of
    a_h2i_no_of: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && $past(req_q.op) == CVT_H2I) |-> !rsp.flags.of
    );

    // Int sources cannot produce a NaN
    a_i2h_no_nan: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && $past(req_q.op) == CVT_I2H) |->
            !((rsp.result[`FPU_HALF_WIDTH-2 -: `FPU_HALF_EXP_WIDTH] ==
               `FPU_HALF_EXP_SPECIAL) &&
              (rsp.result[`FPU_HALF_MAN_WIDTH-1:0] != '0))
    );

endmodule

`default_nettype wire

// ==== hdl/fpu_types_pkg.sv ====
`default_nettype none

`include "fpu_cvt_config.svh"

package fpu_types_pkg;

    // Conversion direction
    typedef enum logic {
        CVT_I2H = 1'b0,
        CVT_H2I = 1'b1
    } cvt_op_e;

    // Rounding modes, codes 5 to 7 are reserved and act as RNE
    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } round_mode_e;

    // Exception flags
    typedef struct packed {
        logic nv;
        logic of;
        logic nx;
    } fpu_flags_t;

    // Request word, a half operand sits in the low bits
    typedef struct packed {
        cvt_op_e                       op;
        round_mode_e                   rm;
        logic [`FPU_CVT_INT_WIDTH-1:0] operand;
    } cvt_req_t;

    // Response word, a half result is zero-extended
    typedef struct packed {
        logic [`FPU_CVT_INT_WIDTH-1:0] result;
        fpu_flags_t                    flags;
    } cvt_rsp_t;

    // Special half encodings
    localparam logic [`FPU_HALF_WIDTH-1:0] HALF_INF  = 16'h7C00;
    localparam logic [`FPU_HALF_WIDTH-1:0] HALF_INFN = 16'hFC00;
    localparam logic [`FPU_HALF_WIDTH-1:0] HALF_MAX  = 16'h7BFF;
    localparam logic [`FPU_HALF_WIDTH-1:0] HALF_MAXN = 16'hFBFF;

    // Decide whether a truncated magnitude gets one added
    function automatic logic round_increment(
        input round_mode_e rm,
        input logic        sign,
        input logic        lsb,
        input logic        guard,
        input logic        sticky
    );
        case (rm)
            RM_RTZ:  return 1'b0;
            RM_RDN:  return sign & (guard | sticky);
            RM_RUP:  return ~sign & (guard | sticky);
            RM_RMM:  return guard;
            // Nearest even, ties go to an even LSB
            default: return guard & (sticky | lsb);
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== tests/fpu_cvt_vectors.svh ====
`ifndef FPU_CVT_VECTORS_SVH
`define FPU_CVT_VECTORS_SVH

// Columns: op, rm, operand, expected result, expected flags {nv, of, nx}
// Half results are zero-extended, half operands sit in the low 16 bits
localparam int NUM_VECTORS = 52;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    // Exact int to half
    {CVT_I2H, RM_RNE, 32'h0000_0000, 32'h0000_0000, 3'b000},
    {CVT_I2H, RM_RNE, 32'h0000_0001, 32'h0000_3C00, 3'b000},
    {CVT_I2H, RM_RNE, 32'hFFFF_FFFF, 32'h0000_BC00, 3'b000},
    {CVT_I2H, RM_RNE, 32'hFFFF_FFFE, 32'h0000_C000, 3'b000},
    {CVT_I2H, RM_RTZ, 32'h0000_0800, 32'h0000_6800, 3'b000},
    {CVT_I2H, RM_RUP, 32'h0000_FFE0, 32'h0000_7BFF, 3'b000},
    // 2049 is a tie between 2048 and 2050
    {CVT_I2H, RM_RNE, 32'h0000_0801, 32'h0000_6800, 3'b001},
    {CVT_I2H, RM_RTZ, 32'h0000_0801, 32'h0000_6800, 3'b001},
    {CVT_I2H, RM_RDN, 32'h0000_0801, 32'h0000_6800, 3'b001},
    {CVT_I2H, RM_RUP, 32'h0000_0801, 32'h0000_6801, 3'b001},
    {CVT_I2H, RM_RMM, 32'h0000_0801, 32'h0000_6801, 3'b001},
    // -2049, away from zero is downward here
    {CVT_I2H, RM_RNE, 32'hFFFF_F7FF, 32'h0000_E800, 3'b001},
    {CVT_I2H, RM_RTZ, 32'hFFFF_F7FF, 32'h0000_E800, 3'b001},
    {CVT_I2H, RM_RDN, 32'hFFFF_F7FF, 32'h0000_E801, 3'b001},
    {CVT_I2H, RM_RUP, 32'hFFFF_F7FF, 32'h0000_E800, 3'b001},
    {CVT_I2H, RM_RMM, 32'hFFFF_F7FF, 32'h0000_E801, 3'b001},
    // 2051 is a tie with an odd kept LSB
    {CVT_I2H, RM_RNE, 32'h0000_0803, 32'h0000_6802, 3'b001},
    {CVT_I2H, RM_RTZ, 32'h0000_0803, 32'h0000_6801, 3'b001},
    {CVT_I2H, RM_RDN, 32'h0000_0803, 32'h0000_6801, 3'b001},
    {CVT_I2H, RM_RUP, 32'h0000_0803, 32'h0000_6802, 3'b001},
    {CVT_I2H, RM_RMM, 32'h0000_0803, 32'h0000_6802, 3'b001},
    // Reserved mode code acts as nearest even
    {CVT_I2H, 3'd7,   32'h0000_0803, 32'h0000_6802, 3'b001},
    // 65520 overflows, max or infinity by direction
    {CVT_I2H, RM_RNE, 32'h0000_FFF0, 32'h0000_7C00, 3'b011},
    {CVT_I2H, RM_RTZ, 32'h0000_FFF0, 32'h0000_7BFF, 3'b011},
    {CVT_I2H, RM_RDN, 32'h0000_FFF0, 32'h0000_7BFF, 3'b011},
    {CVT_I2H, RM_RUP, 32'h0000_FFF0, 32'h0000_7C00, 3'b011},
    {CVT_I2H, RM_RMM, 32'h0000_FFF0, 32'h0000_7C00, 3'b011},
    // -70000
    {CVT_I2H, RM_RNE, 32'hFFFE_EE90, 32'h0000_FC00, 3'b011},
    {CVT_I2H, RM_RTZ, 32'hFFFE_EE90, 32'h0000_FBFF, 3'b011},
    {CVT_I2H, RM_RDN, 32'hFFFE_EE90, 32'h0000_FC00, 3'b011},
    {CVT_I2H, RM_RUP, 32'hFFFE_EE90, 32'h0000_FBFF, 3'b011},
    {CVT_I2H, RM_RMM, 32'hFFFE_EE90, 32'h0000_FC00, 3'b011},
    // 1.5 in every mode, plus a reserved code
    {CVT_H2I, RM_RNE, 32'h0000_3E00, 32'h0000_0002, 3'b001},
    {CVT_H2I, RM_RTZ, 32'h0000_3E00, 32'h0000_0001, 3'b001},
    {CVT_H2I, RM_RDN, 32'h0000_3E00, 32'h0000_0001, 3'b001},
    {CVT_H2I, RM_RUP, 32'h0000_3E00, 32'h0000_0002, 3'b001},
    {CVT_H2I, RM_RMM, 32'h0000_3E00, 32'h0000_0002, 3'b001},
    {CVT_H2I, 3'd5,   32'h0000_3E00, 32'h0000_0002, 3'b001},
    // -1.5
    {CVT_H2I, RM_RNE, 32'h0000_BE00, 32'hFFFF_FFFE, 3'b001},
    {CVT_H2I, RM_RTZ, 32'h0000_BE00, 32'hFFFF_FFFF, 3'b001},
    {CVT_H2I, RM_RDN, 32'h0000_BE00, 32'hFFFF_FFFE, 3'b001},
    // Upper operand bits are ignored, 1.0 is exact
    {CVT_H2I, RM_RDN, 32'hABCD_3C00, 32'h0000_0001, 3'b000},
    // 2.5 ties to even
    {CVT_H2I, RM_RNE, 32'h0000_4100, 32'h0000_0002, 3'b001},
    // 0.5 and the smallest subnormals
    {CVT_H2I, RM_RNE, 32'h0000_3800, 32'h0000_0000, 3'b001},
    {CVT_H2I, RM_RMM, 32'h0000_3800, 32'h0000_0001, 3'b001},
    {CVT_H2I, RM_RNE, 32'h0000_0001, 32'h0000_0000, 3'b001},
    {CVT_H2I, RM_RUP, 32'h0000_0001, 32'h0000_0001, 3'b001},
    {CVT_H2I, RM_RDN, 32'h0000_8001, 32'hFFFF_FFFF, 3'b001},
    // NaN and infinities saturate with invalid
    {CVT_H2I, RM_RNE, 32'h0000_7E00, 32'h7FFF_FFFF, 3'b100},
    {CVT_H2I, RM_RNE, 32'h0000_7C00, 32'h7FFF_FFFF, 3'b100},
    {CVT_H2I, RM_RNE, 32'h0000_FC00, 32'h8000_0000, 3'b100},
    // Largest finite half is 65504
    {CVT_H2I, RM_RNE, 32'h0000_7BFF, 32'h0000_FFE0, 3'b000}
};

`endif

// ==== tests/fpu_cvt_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpu_cvt_config.svh"

module fpu_cvt_tb
    import fpu_types_pkg::*;
();

    // One table row
    typedef struct packed {
        cvt_op_e                       op;
        round_mode_e                   rm;
        logic [`FPU_CVT_INT_WIDTH-1:0] operand;
        logic [`FPU_CVT_INT_WIDTH-1:0] result;
        fpu_flags_t                    flags;
    } vector_t;

    `include "fpu_cvt_vectors.svh"

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 3;
    // Drive step to the step where out_valid shows
    localparam int LATENCY      = 2;
    localparam int WAIT_LIMIT   = 8;
    localparam int RANDOM_COUNT = 200;
    // Two conversions per round trip plus slack
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_VECTORS + LATENCY + 2 +
                                     RANDOM_COUNT * 2 * LATENCY + 50;

    logic     clk;
    logic     rst;
    logic     in_valid;
    cvt_req_t req;
    logic     out_valid;
    cvt_rsp_t rsp;
    int       error_count;

    fpu_cvt_unit fpu_cvt_unit_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    // Inputs change a little after the edge where outputs are stable
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Single strobe and a wait for the result
    task automatic convert(input cvt_op_e op, input round_mode_e rm,
                           input logic [31:0] operand,
                           output logic [31:0] result, output fpu_flags_t flags);
        int waited;
        req      = '{op: op, rm: rm, operand: operand};
        in_valid = 1'b1;
        next_cycle();
        in_valid = 1'b0;
        waited   = 1;
        while (!out_valid && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!out_valid) begin
            report_failure("Timeout: out_valid never rose after a request strobe");
        end
        check_value("out_valid latency", 32'(waited), 32'(LATENCY));
        result = rsp.result;
        flags  = rsp.flags;
    endtask

    initial begin : main
        vector_t     vec;
        int          value;
        round_mode_e rm;
        logic [31:0] half_value;
        logic [31:0] back_value;
        fpu_flags_t  flags_a;
        fpu_flags_t  flags_b;

        rst         = 1'b1;
        in_valid    = 1'b0;
        req         = '0;
        error_count = 0;
        void'($urandom(32'hd277));

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        // Flags come out of reset cleared
        check_value("rsp.flags after reset", 32'(rsp.flags), 32'h0);

        // Rows go in back to back with results trailing by the latency
        for (int k = 0; k < NUM_VECTORS + LATENCY; k++) begin
            check_value("out_valid", 32'(out_valid), 32'(k >= LATENCY));
            if (k >= LATENCY) begin
                vec = VECTORS[k - LATENCY];
                check_value($sformatf("rsp.result row %0d", k - LATENCY),
                            rsp.result, vec.result);
                check_value($sformatf("rsp.flags row %0d", k - LATENCY),
                            32'(rsp.flags), 32'(vec.flags));
            end
            if (k < NUM_VECTORS) begin
                vec      = VECTORS[k];
                req      = '{op: vec.op, rm: vec.rm, operand: vec.operand};
                in_valid = 1'b1;
            end else begin
                // Idle request that must not reach the response
                req      = '{op: CVT_H2I, rm: RM_RNE, operand: 32'h0000_7E00};
                in_valid = 1'b0;
            end
            next_cycle();
        end

        // Strobe drops and the last result stays put
        check_value("out_valid idle", 32'(out_valid), 32'h0);
        vec = VECTORS[NUM_VECTORS - 1];
        check_value("rsp.result hold", rsp.result, vec.result);
        check_value("rsp.flags hold", 32'(rsp.flags), 32'(vec.flags));

        // Integers within 2048 survive the trip through binary16 exactly
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            value = int'($urandom_range(4096)) - 2048;
            rm    = round_mode_e'($urandom_range(4));
            convert(CVT_I2H, rm, 32'(value), half_value, flags_a);
            check_value("rsp.flags int to half", 32'(flags_a), 32'h0);
            convert(CVT_H2I, rm, half_value, back_value, flags_b);
            check_value("rsp.result round trip", back_value, 32'(value));
            check_value("rsp.flags half to int", 32'(flags_b), 32'h0);
        end

        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure($sformatf("Timeout: the run did not finish within %0d clock cycles",
                                 WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire
